//--- filelist.f
verilog/ad_pkg.sv
verilog/ad_cfg_if.sv
verilog/ad_reg.sv
verilog/ad_sample_engine.sv
verilog/ad_byte_serializer.sv
verilog/ad_top.sv
testbench/tb_ad_top.sv

//--- Makefile
# Verilator build for the fx bus converter slot

VERILATOR ?= verilator
TOP       ?= tb_ad_top
FILELIST  ?= filelist.f
FLAGS     ?=
BUILD_DIR ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP) $(FLAGS)

# the simulator exits with a failing status on $$fatal
sim:
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) $(FLAGS)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- testbench/tb_ad_top.sv
// slot id tied to 5; expected values follow the ad_pkg register map and reset defaults
`timescale 1ns/1ns

module tb_ad_top;
	import ad_pkg::*;

	localparam mod_id_t SLOT       = 6'd5;
	localparam mod_id_t OTHER_SLOT = 6'd6;
	localparam int MODE_SKIP = 0;
	localparam int MODE_RAMP = 1;
	localparam int MODE_ADC  = 2;
	// all bus traffic, plus 20 group waits at the longest possible period
	localparam int BUS_CYCLES      = 6 * 256 + 64;
	localparam int GROUP_WAITS     = 20;
	localparam int WATCHDOG_CYCLES = BUS_CYCLES + GROUP_WAITS * (256 + 4) + 500;

	logic      clk_sys;
	logic      rst_n;
	logic      fx_wr;
	reg_addr_t fx_waddr;
	reg_data_t fx_data;
	logic      fx_rd;
	reg_addr_t fx_raddr;
	sample_t   adc_data;
	reg_data_t fx_q;
	reg_data_t ad_byte;
	logic      ad_byte_vld;
	logic      ad_byte_last;

	// register model and expectations
	reg_data_t   exp_reg [256];
	reg_data_t   q_exp = '0;
	int          exp_mode = MODE_RAMP;
	sample_t     ramp_origin = RST_TP_BASE;
	sample_t     adc_exp = '0;
	logic [15:0] lfsr = 16'd53;

	// byte collector state
	int      cyc = 0;
	int      byte_idx = 0;
	int      groups_done = 0;
	int      grp_start = 0;
	int      p_start = 0;
	int      gap_floor = 0;
	int      last_gap = 0;
	int      ramp_k = 0;
	int      mode_seen = MODE_SKIP;
	logic    have_start = 1'b0;
	sample_t word = '0;

	ad_top dut_i (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.mod_id       (SLOT),
		.fx_wr        (fx_wr),
		.fx_waddr     (fx_waddr),
		.fx_data      (fx_data),
		.fx_rd        (fx_rd),
		.fx_raddr     (fx_raddr),
		.adc_data     (adc_data),
		.fx_q         (fx_q),
		.ad_byte      (ad_byte),
		.ad_byte_vld  (ad_byte_vld),
		.ad_byte_last (ad_byte_last)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("test failed");
		$fatal(1);
	endtask

	// one lfsr step per bit taken, taps 16 14 13 11
	function automatic sample_t rand_bits(input int n);
		sample_t v;
		logic    fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			v = {v[22:0], fb};
		end
		return v;
	endfunction

	function automatic logic is_writable(input reg_data_t ofs);
		return (ofs == OFS_SAMPLE) || (ofs == OFS_AD_TP) ||
			(ofs >= OFS_TP_BASE0 && ofs <= OFS_TP_STEP) ||
			(ofs >= OFS_DBG0 && ofs <= OFS_DBG0 + 8'd7);
	endfunction

	function automatic int p_eff();
		if (exp_reg[OFS_SAMPLE] < MIN_PERIOD) begin
			return int'(MIN_PERIOD);
		end
		return int'(exp_reg[OFS_SAMPLE]);
	endfunction

	// ----------------------------------------
	// bus tasks, called 10 ns after a rising edge
	// ----------------------------------------
	task automatic bus_write(input mod_id_t slot, input reg_data_t ofs, input reg_data_t data);
		fx_wr = 1'b1;
		fx_waddr = {2'b00, slot, ofs};
		fx_data = data;
		@(posedge clk_sys);
		#10;
		fx_wr = 1'b0;
		if (slot == SLOT && is_writable(ofs)) begin
			exp_reg[ofs] = data;
		end
	endtask

	task automatic bus_read(input mod_id_t slot, input reg_data_t ofs);
		fx_rd = 1'b1;
		fx_raddr = {2'b00, slot, ofs};
		@(posedge clk_sys);
		#10;
		fx_rd = 1'b0;
		q_exp = (slot == SLOT) ? exp_reg[ofs] : '0;
		@(posedge clk_sys);
		#10;
		q_exp = '0;
	endtask

	task automatic wait_group_end();
		int n;
		n = groups_done;
		while (groups_done == n) begin
			@(posedge clk_sys);
		end
		#10;
	endtask

	task automatic check_gap(input int exp);
		assert (last_gap == exp)
		else fail_now($sformatf("mismatch group gap got 0x%0h exp 0x%0h", last_gap, exp));
	endtask

	task automatic check_word();
		sample_t exp_word;
		// ramp count restarts whenever the expected source changes
		if (exp_mode != mode_seen) begin
			ramp_k = 0;
			mode_seen = exp_mode;
		end
		if (exp_mode == MODE_RAMP) begin
			exp_word = ramp_origin + sample_t'(int'(exp_reg[OFS_TP_STEP]) * ramp_k);
			ramp_k++;
		end else begin
			exp_word = adc_exp;
		end
		if (exp_mode != MODE_SKIP) begin
			assert (word == exp_word)
			else fail_now($sformatf("mismatch ad_byte word got 0x%06h exp 0x%06h", word, exp_word));
		end
	endtask

	// ----------------------------------------
	// monitors, sampled mid cycle
	// ----------------------------------------
	always @(negedge clk_sys) begin
		if (rst_n) begin
			assert (fx_q == q_exp)
			else fail_now($sformatf("mismatch fx_q got 0x%02h exp 0x%02h", fx_q, q_exp));
		end
	end

	always @(negedge clk_sys) begin
		if (rst_n) begin
			cyc++;
			if (ad_byte_vld) begin
				if (byte_idx == 0) begin
					// a period change may land inside a gap
					gap_floor = (p_start < p_eff()) ? p_start : p_eff();
					if (have_start) begin
						last_gap = cyc - grp_start;
						assert (last_gap >= gap_floor)
						else fail_now($sformatf("byte group started only %0d clocks after the last", last_gap));
					end
					have_start = 1'b1;
					grp_start = cyc;
					p_start = p_eff();
				end
				word[byte_idx*8 +: 8] = ad_byte;
				assert (ad_byte_last == (byte_idx == 2))
				else fail_now($sformatf("ad_byte_last wrong on byte %0d of a group", byte_idx));
				if (byte_idx == 2) begin
					check_word();
					byte_idx = 0;
					groups_done++;
				end else begin
					byte_idx++;
				end
			end else begin
				assert (byte_idx == 0 && !ad_byte_last)
				else fail_now("byte group ended before its third byte");
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		fail_now("watchdog expired before the tests finished");
	end

	// ----------------------------------------
	// stimulus
	// ----------------------------------------
	initial begin
		rst_n = 1'b0;
		fx_wr = 1'b0;
		fx_waddr = '0;
		fx_data = '0;
		fx_rd = 1'b0;
		fx_raddr = '0;
		adc_data = '0;
		for (int i = 0; i < 256; i++) begin
			exp_reg[i] = '0;
		end
		exp_reg[OFS_ID] = reg_data_t'(SLOT);
		exp_reg[OFS_SAMPLE] = RST_SAMPLE;
		exp_reg[OFS_AD_TP] = RST_AD_TP;
		exp_reg[OFS_TP_BASE0] = RST_TP_BASE[7:0];
		exp_reg[OFS_TP_BASE1] = RST_TP_BASE[15:8];
		exp_reg[OFS_TP_BASE2] = RST_TP_BASE[23:16];
		exp_reg[OFS_TP_STEP] = RST_TP_STEP;
		for (int n = 0; n < 8; n++) begin
			exp_reg[OFS_DBG0 + reg_data_t'(n)] = RST_DBG0 + reg_data_t'(n);
		end
		repeat (3) @(posedge clk_sys);
		#10;
		rst_n = 1'b1;
		assert (fx_q == '0 && ad_byte == '0 && !ad_byte_vld && !ad_byte_last)
		else fail_now("outputs not cleared by reset");

		// defaults of every offset, then the other slot
		for (int a = 0; a < 256; a++) begin
			bus_read(SLOT, reg_data_t'(a));
		end
		bus_read(OTHER_SLOT, OFS_ID);
		bus_read(OTHER_SLOT, OFS_SAMPLE);
		repeat (3) wait_group_end();

		// random writes, ignored writes to the other slot, readback
		wait_group_end();
		exp_mode = MODE_SKIP;
		for (int a = 0; a < 256; a++) begin
			bus_write(SLOT, reg_data_t'(a), reg_data_t'(rand_bits(8)));
		end
		for (int a = 0; a < 256; a++) begin
			bus_write(OTHER_SLOT, reg_data_t'(a), reg_data_t'(rand_bits(8)));
		end
		for (int a = 0; a < 256; a++) begin
			bus_read(SLOT, reg_data_t'(a));
		end

		// ramp wrap at 24 bits; period goes first so later ticks are 20 apart
		bus_write(SLOT, OFS_SAMPLE, 8'd20);
		bus_write(SLOT, OFS_TP_STEP, 8'd3);
		bus_write(SLOT, OFS_TP_BASE0, 8'hfe);
		bus_write(SLOT, OFS_TP_BASE1, 8'hff);
		bus_write(SLOT, OFS_TP_BASE2, 8'hff);
		bus_write(SLOT, OFS_AD_TP, 8'd0);
		wait_group_end();
		bus_write(SLOT, OFS_AD_TP, 8'd1);
		ramp_origin = 24'hfffffe;
		exp_mode = MODE_RAMP;
		repeat (3) wait_group_end();

		// converter data, changed only right after a group
		adc_data = rand_bits(24);
		adc_exp = adc_data;
		bus_write(SLOT, OFS_AD_TP, 8'd0);
		exp_mode = MODE_ADC;
		repeat (4) begin
			wait_group_end();
			adc_data = rand_bits(24);
			adc_exp = adc_data;
		end

		// period floor, then a longer period
		bus_write(SLOT, OFS_SAMPLE, 8'd1);
		repeat (2) wait_group_end();
		repeat (2) begin
			wait_group_end();
			check_gap(3);
		end
		bus_write(SLOT, OFS_SAMPLE, 8'd7);
		repeat (2) wait_group_end();
		repeat (2) begin
			wait_group_end();
			check_gap(7);
		end

		$display("test passed");
		$finish;
	end

endmodule

//--- verilog/ad_top.sv
// one fx bus slot with the converter front end; adc_data is taken as synchronous to clk_sys
`timescale 1ns/1ns

module ad_top (
	input  logic              clk_sys,
	input  logic              rst_n,
	input  ad_pkg::mod_id_t   mod_id,
	input  logic              fx_wr,
	input  ad_pkg::reg_addr_t fx_waddr,
	input  ad_pkg::reg_data_t fx_data,
	input  logic              fx_rd,
	input  ad_pkg::reg_addr_t fx_raddr,
	input  ad_pkg::sample_t   adc_data,
	output ad_pkg::reg_data_t fx_q,
	output ad_pkg::reg_data_t ad_byte,
	output logic              ad_byte_vld,
	output logic              ad_byte_last
);
	import ad_pkg::*;

	logic    smp_vld;
	sample_t smp_data;

	ad_cfg_if cfg_if ();

	ad_reg reg_i (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.mod_id   (mod_id),
		.fx_wr    (fx_wr),
		.fx_waddr (fx_waddr),
		.fx_data  (fx_data),
		.fx_rd    (fx_rd),
		.fx_raddr (fx_raddr),
		.fx_q     (fx_q),
		.cfg      (cfg_if.regs)
	);

	ad_sample_engine engine_i (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.adc_data (adc_data),
		.cfg      (cfg_if.engine),
		.smp_vld  (smp_vld),
		.smp_data (smp_data)
	);

	ad_byte_serializer ser_i (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.smp_vld      (smp_vld),
		.smp_data     (smp_data),
		.ad_byte      (ad_byte),
		.ad_byte_vld  (ad_byte_vld),
		.ad_byte_last (ad_byte_last)
	);

endmodule

//--- verilog/ad_byte_serializer.sv
// no back-pressure; a new smp_vld is only taken in idle, so samples must be >= 3 clocks apart
`timescale 1ns/1ns

module ad_byte_serializer (
	input  logic              clk_sys,
	input  logic              rst_n,
	input  logic              smp_vld,
	input  ad_pkg::sample_t   smp_data,
	output ad_pkg::reg_data_t ad_byte,
	output logic              ad_byte_vld,
	output logic              ad_byte_last
);
	import ad_pkg::*;

	ser_state_t state;
	sample_t    hold;

	// sample kept for the middle and high bytes
	always_ff @(posedge clk_sys) begin
		if (smp_vld && state == ser_idle) begin
			hold <= smp_data;
		end
	end

	// ----------------------------------------
	// byte FSM, low byte first
	// ----------------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state        <= ser_idle;
			ad_byte      <= '0;
			ad_byte_vld  <= 1'b0;
			ad_byte_last <= 1'b0;
		end else begin
			ad_byte      <= '0;
			ad_byte_vld  <= 1'b0;
			ad_byte_last <= 1'b0;
			case (state)
				ser_idle: begin
					if (smp_vld) begin
						ad_byte     <= smp_data[7:0];
						ad_byte_vld <= 1'b1;
						state       <= ser_b1;
					end
				end
				ser_b1: begin
					ad_byte     <= hold[15:8];
					ad_byte_vld <= 1'b1;
					state       <= ser_b2;
				end
				ser_b2: begin
					ad_byte      <= hold[23:16];
					ad_byte_vld  <= 1'b1;
					ad_byte_last <= 1'b1;
					state        <= ser_idle;
				end
				default: state <= ser_idle;
			endcase
		end
	end

endmodule

//--- verilog/ad_sample_engine.sv
// adc_data must already be synchronous to clk_sys; periods below MIN_PERIOD are raised to it
`timescale 1ns/1ns

module ad_sample_engine (
	input  logic            clk_sys,
	input  logic            rst_n,
	input  ad_pkg::sample_t adc_data,
	ad_cfg_if.engine        cfg,
	output logic            smp_vld,
	output ad_pkg::sample_t smp_data
);
	import ad_pkg::*;

	reg_data_t period;
	reg_data_t cnt;
	logic      tick;
	logic      tp_on;
	logic      tp_prev;
	logic      tp_restart;
	logic      restart_now;
	sample_t   ramp;
	sample_t   ramp_val;

	// ----------------------------------------
	// period counter
	// ----------------------------------------
	assign period = (cfg.sample_period < MIN_PERIOD) ? MIN_PERIOD : cfg.sample_period;

	// >= so a shortened period takes effect at once
	assign tick = (cnt >= period - reg_data_t'(1));

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (tick) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + reg_data_t'(1);
		end
	end

	// ----------------------------------------
	// test ramp control
	// ----------------------------------------
	assign tp_on       = cfg.ad_tp[0];
	assign restart_now = tp_restart | (tp_on & ~tp_prev);
	assign ramp_val    = restart_now ? cfg.tp_base : ramp;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			tp_prev    <= 1'b0;
			tp_restart <= 1'b1;
			smp_vld    <= 1'b0;
		end else begin
			tp_prev <= tp_on;
			smp_vld <= tick;
			// pending restart is consumed by the next ramp capture
			if (tick && tp_on) begin
				tp_restart <= 1'b0;
			end else begin
				tp_restart <= restart_now;
			end
		end
	end

	// capture and ramp advance, wraps at 24 bits
	always_ff @(posedge clk_sys) begin
		if (tick) begin
			smp_data <= tp_on ? ramp_val : adc_data;
			if (tp_on) begin
				ramp <= ramp_val + sample_t'(cfg.tp_step);
			end
		end
	end

endmodule

//--- verilog/ad_reg.sv
// slot match on address bits 13:8; unknown offsets ignore writes and read as 0, fx_q is 0 between reads
`timescale 1ns/1ns

module ad_reg (
	input  logic              clk_sys,
	input  logic              rst_n,
	input  ad_pkg::mod_id_t   mod_id,
	input  logic              fx_wr,
	input  ad_pkg::reg_addr_t fx_waddr,
	input  ad_pkg::reg_data_t fx_data,
	input  logic              fx_rd,
	input  ad_pkg::reg_addr_t fx_raddr,
	output ad_pkg::reg_data_t fx_q,
	ad_cfg_if.regs            cfg
);
	import ad_pkg::*;

	logic      wr_sel;
	logic      rd_sel;
	reg_data_t wr_ofs;
	reg_data_t rd_ofs;

	reg_data_t cfg_sample;
	reg_data_t cfg_ad_tp;
	sample_t   cfg_tp_base;
	reg_data_t cfg_tp_step;
	reg_data_t cfg_dbg [8];
	reg_data_t rd_mux;

	// ----------------------------------------
	// slot decode
	// ----------------------------------------
	assign wr_sel = fx_wr && (fx_waddr[13:8] == mod_id);
	assign rd_sel = fx_rd && (fx_raddr[13:8] == mod_id);
	assign wr_ofs = fx_waddr[7:0];
	assign rd_ofs = fx_raddr[7:0];

	// ----------------------------------------
	// write side
	// ----------------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cfg_sample  <= RST_SAMPLE;
			cfg_ad_tp   <= RST_AD_TP;
			cfg_tp_base <= RST_TP_BASE;
			cfg_tp_step <= RST_TP_STEP;
			for (int i = 0; i < 8; i++) begin
				cfg_dbg[i] <= RST_DBG0 + reg_data_t'(i);
			end
		end else if (wr_sel) begin
			case (wr_ofs)
				OFS_SAMPLE:   cfg_sample <= fx_data;
				OFS_AD_TP:    cfg_ad_tp <= fx_data;
				// base written one byte at a time
				OFS_TP_BASE0: cfg_tp_base[7:0] <= fx_data;
				OFS_TP_BASE1: cfg_tp_base[15:8] <= fx_data;
				OFS_TP_BASE2: cfg_tp_base[23:16] <= fx_data;
				OFS_TP_STEP:  cfg_tp_step <= fx_data;
				default: begin
					// debug bytes at 0x80..0x87
					if (wr_ofs[7:3] == OFS_DBG0[7:3]) begin
						cfg_dbg[wr_ofs[2:0]] <= fx_data;
					end
				end
			endcase
		end
	end

	// ----------------------------------------
	// read side
	// ----------------------------------------
	always_comb begin
		rd_mux = '0;
		case (rd_ofs)
			OFS_ID:       rd_mux = reg_data_t'(mod_id);
			OFS_SAMPLE:   rd_mux = cfg_sample;
			OFS_AD_TP:    rd_mux = cfg_ad_tp;
			OFS_TP_BASE0: rd_mux = cfg_tp_base[7:0];
			OFS_TP_BASE1: rd_mux = cfg_tp_base[15:8];
			OFS_TP_BASE2: rd_mux = cfg_tp_base[23:16];
			OFS_TP_STEP:  rd_mux = cfg_tp_step;
			default: begin
				if (rd_ofs[7:3] == OFS_DBG0[7:3]) begin
					rd_mux = cfg_dbg[rd_ofs[2:0]];
				end
			end
		endcase
	end

	// addressed byte for one cycle, 0 otherwise
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			fx_q <= '0;
		end else if (rd_sel) begin
			fx_q <= rd_mux;
		end else begin
			fx_q <= '0;
		end
	end

	// settings out to the sample engine
	assign cfg.sample_period = cfg_sample;
	assign cfg.ad_tp         = cfg_ad_tp;
	assign cfg.tp_base       = cfg_tp_base;
	assign cfg.tp_step       = cfg_tp_step;

endmodule

//--- verilog/ad_cfg_if.sv
// configuration values are plain levels with no handshake; they change one clock after a bus write
`timescale 1ns/1ns

interface ad_cfg_if;
	import ad_pkg::*;

	// sample period in clocks, floored by the engine
	reg_data_t sample_period;
	// bit 0 selects the test ramp
	reg_data_t ad_tp;
	sample_t   tp_base;
	reg_data_t tp_step;

	modport regs (
		output sample_period, ad_tp, tp_base, tp_step
	);

	modport engine (
		input sample_period, ad_tp, tp_base, tp_step
	);

endinterface

//--- verilog/ad_pkg.sv
// fx bus register map and types for one slot; offsets are fixed and MIN_PERIOD must stay >= 3
package ad_pkg;

	typedef logic [15:0] reg_addr_t;
	typedef logic [7:0]  reg_data_t;
	typedef logic [5:0]  mod_id_t;
	typedef logic [23:0] sample_t;

	typedef enum logic [1:0] {
		ser_idle,
		ser_b1,
		ser_b2
	} ser_state_t;

	// register offsets inside the slot
	localparam reg_data_t OFS_ID       = 8'h00;
	localparam reg_data_t OFS_SAMPLE   = 8'h20;
	localparam reg_data_t OFS_AD_TP    = 8'h40;
	localparam reg_data_t OFS_TP_BASE0 = 8'h44;
	localparam reg_data_t OFS_TP_BASE1 = 8'h45;
	localparam reg_data_t OFS_TP_BASE2 = 8'h46;
	localparam reg_data_t OFS_TP_STEP  = 8'h47;
	localparam reg_data_t OFS_DBG0     = 8'h80;

	// reset values, debug n resets to RST_DBG0 + n
	localparam reg_data_t RST_SAMPLE  = 8'd20;
	localparam reg_data_t RST_AD_TP   = 8'd1;
	localparam sample_t   RST_TP_BASE = 24'h0;
	localparam reg_data_t RST_TP_STEP = 8'd1;
	localparam reg_data_t RST_DBG0    = 8'h80;

	// three byte strobes must fit between two samples
	localparam reg_data_t MIN_PERIOD = 8'd3;

endpackage
